// File: uart_config.svh
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

`default_nettype none

// Clk_UART cycles per 16x enable
// Default of 4 gives 64 clocks per serial bit
`define UART_BAUD_DIV   4

// Enables per serial bit
`define UART_OVERSAMPLE 16

// Widest character on the line
`define UART_DATA_W     8

// Status word width
// One bit per entry of UartPkg::tStatBit
`define UART_STAT_W     5

`default_nettype wire

`endif

// File: UartPkg.sv
`default_nettype none

package UartPkg;

    ////////////////////////////////////////////////////////////
    // Parity selection as driven on the par inputs

    typedef enum logic [1:0] {
        parOdd   = 2'd0,    // Odd number of ones incl. parity bit
        parEven  = 2'd1,    // Even number of ones incl. parity bit
        parSpace = 2'd2,    // Parity bit fixed at 0
        parMark  = 2'd3     // Parity bit fixed at 1
    } tParity;

    ////////////////////////////////////////////////////////////
    // Bit positions within the status word

    typedef enum logic [2:0] {
        statRxRdy  = 3'd0,  // Byte waiting in rxHold
        statParErr = 3'd1,  // Sticky parity error
        statFrmErr = 3'd2,  // Sticky framing error
        statOvr    = 3'd3,  // Byte overwritten before clear
        statTxIdle = 3'd4   // Live transmitter idle
    } tStatBit;

endpackage

`default_nettype wire

// File: UartBaudGen.sv
`timescale 1ns/1ps
`include "uart_config.svh"
`default_nettype none

module UartBaudGen #(
    parameter int pDiv = `UART_BAUD_DIV    // Clk_UART cycles per enable
) (
    input  logic Clk_UART,
    input  logic nMCLR,
    output logic ce16x      // One-cycle 16x bit-rate enable
);

    // Counter needs at least one bit even for pDiv of 1
    localparam int cCntW = (pDiv > 1) ? $clog2(pDiv) : 1;
    localparam logic [cCntW-1:0] cReload = cCntW'(pDiv - 1);

    logic [cCntW-1:0] divCnt;   // Counts down to zero then reloads

    // Enable is registered off the terminal count
    // First enable lands pDiv cycles after reset release
    always_ff @(posedge Clk_UART or negedge nMCLR) begin
        if (!nMCLR) begin
            divCnt <= cReload;
            ce16x  <= 1'b0;
        end else begin
            if (divCnt == '0) begin
                divCnt <= cReload;          // Wrap
            end else begin
                divCnt <= divCnt - 1'b1;
            end
            ce16x <= (divCnt == '0);        // Single pulse per period
        end
    end

endmodule

`default_nettype wire

// File: UartTxSm.sv
`timescale 1ns/1ps
`include "uart_config.svh"
`default_nettype none

module UartTxSm (
    input  logic                    Clk_UART,
    input  logic                    nMCLR,
    input  logic                    ce16x,      // 16x bit-rate enable
    input  logic                    len,        // Seven data bits when set
    input  logic                    numStop,    // Two stop bits when set
    input  logic                    parEn,      // Parity bit enable
    input  UartPkg::tParity         par,
    input  logic                    thrEmpty,   // Holding register empty flag
    input  logic [`UART_DATA_W-1:0] thr,        // Holding register
    output logic                    thrRe,      // Holding register read strobe
    output logic                    td,         // Serial out, idles high
    output logic                    txIdle,
    output logic                    txStart,
    output logic                    txShift,
    output logic                    txStop
);

    import UartPkg::*;

    localparam int cOvsW = $clog2(`UART_OVERSAMPLE);
    localparam int cBitW = $clog2(`UART_DATA_W);
    localparam logic [cOvsW-1:0] cLast = cOvsW'(`UART_OVERSAMPLE - 1);

    typedef enum logic [2:0] {
        sIdle,
        sStart,
        sShift,
        sParity,
        sStop
    } tTxState;

    tTxState                 state;
    logic [cOvsW-1:0]        ovsCnt;    // Enables into current bit
    logic [cBitW-1:0]        bitCnt;    // Data bits or stop bits sent
    logic [`UART_DATA_W-1:0] txSr;      // Outgoing character, LSB first
    logic                    parAcc;    // XOR of data bits already sent
    logic                    bitEnd;    // Last enable of a bit time
    logic                    lastData;
    logic                    lastStop;
    logic                    parBit;

    assign bitEnd   = ce16x && (ovsCnt == cLast);
    assign lastData = (bitCnt == (len ? cBitW'(`UART_DATA_W - 2) : cBitW'(`UART_DATA_W - 1)));
    assign lastStop = (bitCnt == cBitW'(numStop));

    // Fetch happens only on an enable so the strobe is one cycle wide
    assign thrRe = ce16x && (state == sIdle) && !thrEmpty;

    ////////////////////////////////////////////////////////////
    // Parity bit from accumulated data

    always_comb begin
        case (par)
            parOdd:   parBit = ~parAcc;
            parEven:  parBit = parAcc;
            parSpace: parBit = 1'b0;
            parMark:  parBit = 1'b1;
            default:  parBit = 1'b1;
        endcase
    end

    // Line level decoded from state
    always_comb begin
        case (state)
            sStart:  td = 1'b0;         // Start bit
            sShift:  td = txSr[0];
            sParity: td = parBit;
            default: td = 1'b1;         // Idle and stop bits
        endcase
    end

    assign txIdle  = (state == sIdle);
    assign txStart = (state == sStart);
    assign txShift = (state == sShift) || (state == sParity);
    assign txStop  = (state == sStop);

    ////////////////////////////////////////////////////////////
    // Frame sequencer

    always_ff @(posedge Clk_UART or negedge nMCLR) begin
        if (!nMCLR) begin
            state  <= sIdle;
            ovsCnt <= '0;
            bitCnt <= '0;
            parAcc <= 1'b0;
        end else if (ce16x) begin
            ovsCnt <= (state == sIdle) ? '0 : ovsCnt + 1'b1;   // Wraps each bit
            case (state)
                sIdle: begin
                    if (!thrEmpty) begin
                        state  <= sStart;   // Same cycle as thrRe
                        parAcc <= 1'b0;
                    end
                end
                sStart: begin
                    if (bitEnd) begin
                        state  <= sShift;
                        bitCnt <= '0;
                    end
                end
                sShift: begin
                    if (bitEnd) begin
                        parAcc <= parAcc ^ txSr[0];
                        bitCnt <= bitCnt + 1'b1;
                        if (lastData) begin
                            state  <= parEn ? sParity : sStop;
                            bitCnt <= '0;   // Reused as stop counter
                        end
                    end
                end
                sParity: begin
                    if (bitEnd) begin
                        state <= sStop;
                    end
                end
                sStop: begin
                    if (bitEnd) begin
                        bitCnt <= bitCnt + 1'b1;
                        if (lastStop) begin
                            state <= sIdle;
                        end
                    end
                end
                default: state <= sIdle;
            endcase
        end
    end

    // Shift register loads on the fetch strobe
    always_ff @(posedge Clk_UART) begin
        if (thrRe) begin
            txSr <= thr;
        end else if (bitEnd && (state == sShift)) begin
            txSr <= txSr >> 1;
        end
    end

endmodule

`default_nettype wire

// File: UartRxSm.sv
`timescale 1ns/1ps
`include "uart_config.svh"
`default_nettype none

module UartRxSm (
    input  logic                    Clk_UART,
    input  logic                    nMCLR,
    input  logic                    ce16x,      // 16x bit-rate enable
    input  logic                    len,        // Seven data bits when set
    input  logic                    numStop,    // Two stop bits when set
    input  logic                    parEn,      // Parity bit expected
    input  UartPkg::tParity         par,
    input  logic                    rd,         // Serial in, asynchronous
    output logic [`UART_DATA_W-1:0] rxData,
    output logic                    rxValid,    // One-cycle byte strobe
    output logic                    parErr,
    output logic                    frmErr
);

    import UartPkg::*;

    localparam int cOvsW = $clog2(`UART_OVERSAMPLE);
    localparam int cBitW = $clog2(`UART_DATA_W);
    localparam logic [cOvsW-1:0] cMid  = cOvsW'(`UART_OVERSAMPLE / 2 - 1);
    localparam logic [cOvsW-1:0] cLast = cOvsW'(`UART_OVERSAMPLE - 1);

    typedef enum logic [2:0] {
        sHunt,
        sStart,
        sData,
        sParity,
        sStop
    } tRxState;

    tRxState                 state;
    logic [1:0]              rdSync;    // Two-flop synchronizer
    logic                    rdS;       // Synchronized line
    logic                    rdLast;    // Line at previous enable
    logic [cOvsW-1:0]        ovsCnt;    // Enables since last centre
    logic [cBitW-1:0]        bitCnt;    // Data bits or stop bits taken
    logic [`UART_DATA_W-1:0] rxSr;      // Fills from the top, LSB first
    logic                    parAcc;    // XOR of received data bits
    logic                    centre;    // Enable at a bit centre
    logic                    lastData;
    logic                    lastStop;
    logic                    parExp;    // Parity bit the sender should send

    assign rdS      = rdSync[1];
    assign centre   = ce16x && (ovsCnt == cLast);
    assign lastData = (bitCnt == (len ? cBitW'(`UART_DATA_W - 2) : cBitW'(`UART_DATA_W - 1)));
    assign lastStop = (bitCnt == cBitW'(numStop));

    // Seven-bit characters sit one place high in the shifter
    assign rxData = len ? {1'b0, rxSr[`UART_DATA_W-1:1]} : rxSr;

    always_comb begin
        case (par)
            parOdd:   parExp = ~parAcc;
            parEven:  parExp = parAcc;
            parSpace: parExp = 1'b0;
            parMark:  parExp = 1'b1;
            default:  parExp = 1'b1;
        endcase
    end

    always_ff @(posedge Clk_UART or negedge nMCLR) begin
        if (!nMCLR) begin
            rdSync <= 2'b11;                // Line idles high
        end else begin
            rdSync <= {rdSync[0], rd};
        end
    end

    ////////////////////////////////////////////////////////////
    // Start hunt, centre sampling and frame checks

    always_ff @(posedge Clk_UART or negedge nMCLR) begin
        if (!nMCLR) begin
            state   <= sHunt;
            rdLast  <= 1'b1;
            ovsCnt  <= '0;
            bitCnt  <= '0;
            parAcc  <= 1'b0;
            parErr  <= 1'b0;
            frmErr  <= 1'b0;
            rxValid <= 1'b0;
        end else begin
            rxValid <= 1'b0;                // Default low, pulses for one cycle
            if (ce16x) begin
                rdLast <= rdS;
                ovsCnt <= ovsCnt + 1'b1;
                case (state)
                    sHunt: begin
                        // High to low arms detection and realigns the count
                        if (rdLast && !rdS) begin
                            state  <= sStart;
                            ovsCnt <= '0;
                        end
                    end
                    sStart: begin
                        if (ovsCnt == cMid) begin   // Mid start bit
                            ovsCnt <= '0;
                            if (rdS) begin
                                state <= sHunt;     // Glitch, not a start bit
                            end else begin
                                state  <= sData;
                                bitCnt <= '0;
                                parAcc <= 1'b0;
                                parErr <= 1'b0;
                                frmErr <= 1'b0;
                            end
                        end
                    end
                    sData: begin
                        if (centre) begin
                            parAcc <= parAcc ^ rdS;
                            bitCnt <= bitCnt + 1'b1;
                            if (lastData) begin
                                state  <= parEn ? sParity : sStop;
                                bitCnt <= '0;
                            end
                        end
                    end
                    sParity: begin
                        if (centre) begin
                            parErr <= (rdS != parExp);
                            state  <= sStop;
                        end
                    end
                    sStop: begin
                        if (centre) begin
                            frmErr <= frmErr | !rdS;    // Any low stop bit
                            bitCnt <= bitCnt + 1'b1;
                            if (lastStop) begin
                                rxValid <= 1'b1;        // Byte and flags ready
                                state   <= sHunt;
                            end
                        end
                    end
                    default: state <= sHunt;
                endcase
            end
        end
    end

    // Data shifter holds its value through stop and hunt
    always_ff @(posedge Clk_UART) begin
        if (centre && (state == sData)) begin
            rxSr <= {rdS, rxSr[`UART_DATA_W-1:1]};
        end
    end

endmodule

`default_nettype wire

// File: UartStatus.sv
`timescale 1ns/1ps
`include "uart_config.svh"
`default_nettype none

module UartStatus (
    input  logic                    Clk_UART,
    input  logic                    nMCLR,
    input  logic                    rxValid,    // Receive byte strobe
    input  logic [`UART_DATA_W-1:0] rxData,
    input  logic                    parErr,
    input  logic                    frmErr,
    input  logic                    txIdle,     // Live from transmitter
    input  logic                    statClr,    // Clears sticky bits
    output logic [`UART_STAT_W-1:0] status,
    output logic [`UART_DATA_W-1:0] rxHold,     // Last received byte
    output logic                    irq
);

    import UartPkg::*;

    logic rxRdy;    // Byte not yet acknowledged
    logic parSt;    // Sticky parity error
    logic frmSt;    // Sticky framing error
    logic ovrSt;    // Sticky overrun

    // A byte arriving with statClr still counts as new
    always_ff @(posedge Clk_UART or negedge nMCLR) begin
        if (!nMCLR) begin
            rxRdy <= 1'b0;
            parSt <= 1'b0;
            frmSt <= 1'b0;
            ovrSt <= 1'b0;
        end else begin
            rxRdy <= (rxRdy & ~statClr) | rxValid;
            parSt <= (parSt & ~statClr) | (rxValid & parErr);
            frmSt <= (frmSt & ~statClr) | (rxValid & frmErr);
            ovrSt <= (ovrSt & ~statClr) | (rxValid & rxRdy & ~statClr);  // Unread byte lost
        end
    end

    always_ff @(posedge Clk_UART) begin
        if (rxValid) begin
            rxHold <= rxData;       // Newest byte always kept
        end
    end

    always_comb begin
        status             = '0;
        status[statRxRdy]  = rxRdy;
        status[statParErr] = parSt;
        status[statFrmErr] = frmSt;
        status[statOvr]    = ovrSt;
        status[statTxIdle] = txIdle;
    end

    assign irq = rxRdy | parSt | frmSt | ovrSt;   // Transmit idle not an interrupt source

endmodule

`default_nettype wire

// File: Uart.sv
`timescale 1ns/1ps
`include "uart_config.svh"
`default_nettype none

module Uart (
    input  logic                    Clk_UART,
    input  logic                    nMCLR,
    input  logic                    len,        // Seven data bits when set
    input  logic                    numStop,    // Two stop bits when set
    input  logic                    parEn,
    input  UartPkg::tParity         par,
    input  logic                    thrEmpty,
    input  logic [`UART_DATA_W-1:0] thr,
    input  logic                    rd,
    input  logic                    statClr,
    output logic                    thrRe,
    output logic                    td,
    output logic                    txIdle,
    output logic [`UART_DATA_W-1:0] rxHold,
    output logic [`UART_STAT_W-1:0] status,
    output logic                    irq
);

    logic                    ce16x;     // Shared bit-rate enable
    logic [`UART_DATA_W-1:0] rxData;
    logic                    rxValid;
    logic                    parErr;
    logic                    frmErr;

    UartBaudGen #(
        .pDiv(`UART_BAUD_DIV)
    ) UartBaudGen_i (
        .Clk_UART(Clk_UART),
        .nMCLR   (nMCLR),
        .ce16x   (ce16x)
    );

    // CTS held asserted so no start wait and no flow-control outputs used
    UartTxSm UartTxSm_i (
        .Clk_UART(Clk_UART),
        .nMCLR   (nMCLR),
        .ce16x   (ce16x),
        .len     (len),
        .numStop (numStop),
        .parEn   (parEn),
        .par     (par),
        .thrEmpty(thrEmpty),
        .thr     (thr),
        .thrRe   (thrRe),
        .td      (td),
        .txIdle  (txIdle),
        .txStart (),
        .txShift (),
        .txStop  ()
    );

    UartRxSm UartRxSm_i (
        .Clk_UART(Clk_UART),
        .nMCLR   (nMCLR),
        .ce16x   (ce16x),
        .len     (len),
        .numStop (numStop),
        .parEn   (parEn),
        .par     (par),
        .rd      (rd),
        .rxData  (rxData),
        .rxValid (rxValid),
        .parErr  (parErr),
        .frmErr  (frmErr)
    );

    UartStatus UartStatus_i (
        .Clk_UART(Clk_UART),
        .nMCLR   (nMCLR),
        .rxValid (rxValid),
        .rxData  (rxData),
        .parErr  (parErr),
        .frmErr  (frmErr),
        .txIdle  (txIdle),
        .statClr (statClr),
        .status  (status),
        .rxHold  (rxHold),
        .irq     (irq)
    );

endmodule

`default_nettype wire

// File: UartClkGen.sv
`timescale 1ns/1ps
`default_nettype none

module UartClkGen #(
    parameter int pPeriod    = 100,    // Clock period in ns
    parameter int pRstCycles = 5       // Clocks with reset held low
) (
    output logic Clk_UART,
    output logic nMCLR
);

    initial begin
        Clk_UART = 1'b0;
        forever begin
            #(pPeriod / 2) Clk_UART = ~Clk_UART;
        end
    end

    initial begin
        nMCLR = 1'b0;
        repeat (pRstCycles) @(posedge Clk_UART);
        @(negedge Clk_UART);
        nMCLR = 1'b1;                  // Release away from the active edge
    end

endmodule

`default_nettype wire

// File: Uart_props.sv
`timescale 1ns/1ps
`default_nettype none

module Uart_props (
    input logic Clk_UART,
    input logic nMCLR,
    input logic thrRe,
    input logic td,
    input logic txIdle,
    input logic rxValid
);

    int failCnt = 0;    // Failures seen, summed by tb_Uart at the end

    // Fetch strobe is a single cycle wide
    thrReSingle: assert property (@(posedge Clk_UART) disable iff (!nMCLR)
        thrRe |=> !thrRe)
        else begin
            $error("thrRe held high for more than one cycle");
            failCnt++;
        end

    // Line rests high while idle and was already high the cycle before
    // Idle is only ever entered from a high stop bit
    tdIdleHigh: assert property (@(posedge Clk_UART) disable iff (!nMCLR)
        txIdle |-> td && $past(td))
        else begin
            $error("td low while txIdle is high or in the cycle before it");
            failCnt++;
        end

    rxValidSingle: assert property (@(posedge Clk_UART) disable iff (!nMCLR)
        rxValid |=> !rxValid)
        else begin
            $error("rxValid high on two cycles running");
            failCnt++;
        end

endmodule

////////////////////////////////////////////////////////////
// One instance per state machine, unused inputs tied off

bind UartTxSm Uart_props txProps_i (
    .Clk_UART(Clk_UART),
    .nMCLR   (nMCLR),
    .thrRe   (thrRe),
    .td      (td),
    .txIdle  (txIdle),
    .rxValid (1'b0)
);

bind UartRxSm Uart_props rxProps_i (
    .Clk_UART(Clk_UART),
    .nMCLR   (nMCLR),
    .thrRe   (1'b0),
    .td      (1'b1),
    .txIdle  (1'b0),
    .rxValid (rxValid)
);

`default_nettype wire

// File: tb_Uart.sv
`timescale 1ns/1ps
`include "uart_config.svh"
`default_nettype none

module tb_Uart;

    import UartPkg::*;

    localparam int cBitClks = `UART_BAUD_DIV * `UART_OVERSAMPLE;   // Clocks per serial bit
    localparam logic [`UART_STAT_W-1:0] cIdleStat = 1 << statTxIdle;

    typedef struct packed {
        logic                    len;
        logic                    numStop;
        logic                    parEn;
        logic [1:0]              par;
        logic [`UART_DATA_W-1:0] data;
        logic                    corrupt;   // First stop bit driven low on rd
        logic                    flip;      // Wrong parity bit on rd
        logic                    keep;      // No clear after this case
        logic                    expPar;
        logic                    expFrm;
        logic                    expOvr;
    } tCase;

    logic                    Clk_UART;
    logic                    nMCLR;
    logic                    len;
    logic                    numStop;
    logic                    parEn;
    tParity                  par;
    logic                    thrEmpty;
    logic [`UART_DATA_W-1:0] thr;
    logic                    rd;
    logic                    statClr;
    logic                    thrRe;
    logic                    td;
    logic                    txIdle;
    logic [`UART_DATA_W-1:0] rxHold;
    logic [`UART_STAT_W-1:0] status;
    logic                    irq;

    tCase cases[$];
    logic frameBits[$];     // Line levels of one frame, start bit first
    int   errors    = 0;
    int   caseErrs  = 0;
    int   checks    = 0;
    int   thrReCnt  = 0;    // Fetch strobes seen at clock edges
    int   cycleCnt  = 0;
    int   cycleLimit = 0;   // Zero until the case count is known
    int   propFails;

    UartClkGen #(.pPeriod(100), .pRstCycles(5)) UartClkGen_i (
        .Clk_UART(Clk_UART),
        .nMCLR   (nMCLR)
    );

    Uart Uart_i (
        .Clk_UART(Clk_UART),
        .nMCLR   (nMCLR),
        .len     (len),
        .numStop (numStop),
        .parEn   (parEn),
        .par     (par),
        .thrEmpty(thrEmpty),
        .thr     (thr),
        .rd      (rd),
        .statClr (statClr),
        .thrRe   (thrRe),
        .td      (td),
        .txIdle  (txIdle),
        .rxHold  (rxHold),
        .status  (status),
        .irq     (irq)
    );

    always @(posedge Clk_UART) begin
        if (thrRe) begin
            thrReCnt <= thrReCnt + 1;
        end
    end

    // Hang guard sized from the case count
    always @(posedge Clk_UART) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleLimit > 0 && cycleCnt >= cycleLimit) begin
            $display("Run stopped at %0t after %0d cycles without finishing", $time, cycleCnt);
            $display("Something failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Case file and frame building

    task automatic readCases();
        int    fd;
        int    n;
        int    v[11];
        string line;
        tCase  tc;
        fd = $fopen("uart_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open uart_cases.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%d %d %d %d %h %d %d %d %d %d %d", v[0], v[1], v[2], v[3],
                        v[4], v[5], v[6], v[7], v[8], v[9], v[10]);
            if (n == 11) begin      // Comment and blank lines fall through
                tc = {v[0][0], v[1][0], v[2][0], v[3][1:0], v[4][`UART_DATA_W-1:0],
                      v[5][0], v[6][0], v[7][0], v[8][0], v[9][0], v[10][0]};
                cases.push_back(tc);
            end
        end
        $fclose(fd);
    endtask

    function automatic logic parityBit(input logic [`UART_DATA_W-1:0] d, input logic seven,
                                       input logic [1:0] mode);
        logic ones;
        ones = seven ? ^d[`UART_DATA_W-2:0] : ^d;    // Odd count of ones
        case (mode)
            parOdd:   parityBit = ~ones;
            parEven:  parityBit = ones;
            parSpace: parityBit = 1'b0;
            default:  parityBit = 1'b1;
        endcase
    endfunction

    // Faults applies the corruption columns, used on rd only
    task automatic makeFrame(input tCase tc, input logic faults);
        int nData;
        frameBits.delete();
        nData = tc.len ? `UART_DATA_W - 1 : `UART_DATA_W;
        frameBits.push_back(1'b0);
        for (int i = 0; i < nData; i++) begin
            frameBits.push_back(tc.data[i]);        // LSB first
        end
        if (tc.parEn) begin
            frameBits.push_back(parityBit(tc.data, tc.len, tc.par) ^ (faults & tc.flip));
        end
        frameBits.push_back(!(faults && tc.corrupt));
        if (tc.numStop) begin
            frameBits.push_back(1'b1);
        end
    endtask

    task automatic compareValue(input string sig, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("** Error at %0t: %s is %0h, expected %0h", $time, sig, got, exp);
            errors++;
            caseErrs++;
        end
    endtask

    task automatic awaitStatusBit(input int pos);
        int n;
        n = 0;
        while (status[pos] !== 1'b1 && n < 2 * cBitClks) begin
            @(negedge Clk_UART);
            n++;
        end
        if (status[pos] !== 1'b1) begin
            $display("Receive strobe never arrived, status bit %0d still low at %0t", pos, $time);
            errors++;
            caseErrs++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Transmit, receive and clear sequences

    task automatic checkTxFrame(input tCase tc);
        int n;
        int pulsesBefore;
        makeFrame(tc, 1'b0);
        pulsesBefore = thrReCnt;
        thr      = tc.data;
        thrEmpty = 1'b0;                            // Byte waiting in holding register
        n = 0;
        @(negedge Clk_UART);
        while (thrReCnt == pulsesBefore && n < 8 * `UART_BAUD_DIV) begin
            @(negedge Clk_UART);
            n++;
        end
        thrEmpty = 1'b1;
        if (thrReCnt == pulsesBefore) begin
            $display("Transmitter never fetched the holding register at %0t", $time);
            errors++;
            caseErrs++;
            return;
        end
        repeat (cBitClks / 2 - 1) @(negedge Clk_UART);  // To start bit centre
        foreach (frameBits[i]) begin
            compareValue($sformatf("td bit %0d", i), td, frameBits[i]);
            repeat (cBitClks) @(negedge Clk_UART);
        end
        n = 0;
        while (!txIdle && n < cBitClks) begin
            @(negedge Clk_UART);
            n++;
        end
        compareValue("thrRe pulses", thrReCnt - pulsesBefore, 1);
        compareValue("txIdle", txIdle, 1'b1);
        compareValue("td", td, 1'b1);
    endtask

    task automatic driveRxFrame(input tCase tc);
        makeFrame(tc, 1'b1);
        foreach (frameBits[i]) begin
            rd = frameBits[i];
            repeat (cBitClks) @(negedge Clk_UART);
        end
        rd = 1'b1;                                  // Back to idle after a low stop bit
    endtask

    task automatic clearStatus();
        statClr = 1'b1;
        @(negedge Clk_UART);
        statClr = 1'b0;
        @(negedge Clk_UART);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        len      = 1'b0;
        numStop  = 1'b0;
        parEn    = 1'b0;
        par      = parOdd;
        thrEmpty = 1'b1;
        thr      = '0;
        rd       = 1'b1;
        statClr  = 1'b0;
        readCases();
        if (cases.size() == 0) begin
            $display("No cases read from uart_cases.txt");
            errors++;
        end
        cycleLimit = cases.size() * (2 * 12 * cBitClks + 256) + 1000;
        @(posedge nMCLR);
        repeat (2) @(negedge Clk_UART);
        compareValue("td", td, 1'b1);
        compareValue("thrRe", thrRe, 1'b0);
        compareValue("irq", irq, 1'b0);
        compareValue("status", status, cIdleStat);
        $display("Reset: %0d errors", caseErrs);
        foreach (cases[k]) begin
            caseErrs = 0;
            len      = cases[k].len;                // Both machines idle here
            numStop  = cases[k].numStop;
            parEn    = cases[k].parEn;
            par      = tParity'(cases[k].par);
            @(negedge Clk_UART);
            checkTxFrame(cases[k]);
            driveRxFrame(cases[k]);
            awaitStatusBit(cases[k].expOvr ? statOvr : statRxRdy);
            compareValue("rxHold", rxHold,
                         cases[k].data & (cases[k].len ? 8'h7F : 8'hFF));
            compareValue("status rx ready", status[statRxRdy], 1'b1);
            compareValue("status parity", status[statParErr], cases[k].expPar);
            compareValue("status framing", status[statFrmErr], cases[k].expFrm);
            compareValue("status overrun", status[statOvr], cases[k].expOvr);
            compareValue("irq", irq, 1'b1);
            if (!cases[k].keep) begin
                clearStatus();
                compareValue("status", status, cIdleStat);
                compareValue("irq", irq, 1'b0);
                compareValue("td", td, 1'b1);
            end
            $display("Case %0d byte %h len %0d stop %0d parEn %0d par %0d: %0d errors",
                     k, cases[k].data, cases[k].len, cases[k].numStop, cases[k].parEn,
                     cases[k].par, caseErrs);
        end
        repeat (cBitClks) @(negedge Clk_UART);
        propFails = Uart_i.UartTxSm_i.txProps_i.failCnt + Uart_i.UartRxSm_i.rxProps_i.failCnt;
        if (propFails != 0) begin
            $display("Assertions failed %0d times", propFails);
            errors += propFails;
        end
        $display("Cases %0d, checks %0d, errors %0d", cases.size(), checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: uart_cases.txt
# len numStop parEn par(0 odd 1 even 2 space 3 mark) byte(hex) corrupt flipPar keep
# then the expected flags: parErr frmErr overrun
0 0 0 0 A5 0 0 0 0 0 0
0 1 1 0 3C 0 0 0 0 0 0
0 0 1 1 5A 0 0 0 0 0 0
1 0 1 2 7E 0 0 0 0 0 0
1 1 1 3 C3 0 0 0 0 0 0
0 0 1 1 81 0 1 0 1 0 0
0 0 1 0 6B 0 1 0 1 0 0
0 0 0 0 81 0 1 0 0 0 0
0 0 0 0 F0 1 0 0 0 1 0
0 1 1 0 0F 1 0 0 0 1 0
0 0 0 0 12 0 0 1 0 0 0
0 0 0 0 34 0 0 0 0 0 1
1 0 0 0 FF 0 0 0 0 0 0

// File: build.f
+incdir+.
UartPkg.sv
UartBaudGen.sv
UartTxSm.sv
UartRxSm.sv
UartStatus.sv
Uart.sv
UartClkGen.sv
Uart_props.sv
tb_Uart.sv

// File: Bender.yml
package:
  name: uart

export_include_dirs:
  - .

sources:
  - UartPkg.sv
  - UartBaudGen.sv
  - UartTxSm.sv
  - UartRxSm.sv
  - UartStatus.sv
  - Uart.sv
  - target: test
    files:
      - UartClkGen.sv
      - Uart_props.sv
      - tb_Uart.sv
